// File: hw/ar_burst_splitter.sv
// ============================
// Splits one AXI4 AR burst into len+1 single Lite reads and pushes
// one burst tag (id, len) for the R side. FIXED and INCR only.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module ar_burst_splitter (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  logic [`AXI_ID_BITS-1:0]    ar_id,
  input  logic [`AXI_ADDR_BITS-1:0]  ar_addr,
  input  logic [`AXI_LEN_BITS-1:0]   ar_len,
  input  logic [`AXI_SIZE_BITS-1:0]  ar_size,
  input  axi_bridge_pkg::burst_e     ar_burst,
  input  logic [`AXI_PROT_BITS-1:0]  ar_prot,
  lite_ar_if.master                  req,
  burst_tag_if.master                tag
);

  axi_bridge_pkg::split_state_e state;

  logic [`AXI_ID_BITS-1:0]   id_q;
  logic [`AXI_LEN_BITS-1:0]  len_q;
  logic [`AXI_SIZE_BITS-1:0] size_q;
  axi_bridge_pkg::burst_e    burst_q;
  logic [`AXI_PROT_BITS-1:0] prot_q;
  logic [`AXI_ADDR_BITS-1:0] base_q;
  logic [`AXI_ADDR_BITS-1:0] addr_q;
  logic [`AXI_LEN_BITS-1:0]  beat_cnt;
  logic                      tag_pending;

  logic                      ar_fire;
  logic                      beat_fire;
  logic                      last_beat;
  logic [`AXI_ADDR_BITS-1:0] next_addr;

  // A new burst only when the tag FIFO can take its tag
  assign ar_ready  = (state == axi_bridge_pkg::SPLIT_IDLE) && tag.ready;
  assign ar_fire   = ar_valid && ar_ready;
  assign beat_fire = req.valid && req.ready;
  assign last_beat = (beat_cnt == len_q);

  assign req.valid = (state == axi_bridge_pkg::SPLIT_ISSUE);
  assign req.addr  = addr_q;
  assign req.prot  = prot_q;

  assign tag.valid = tag_pending;
  assign tag.id    = id_q;
  assign tag.len   = len_q;

  // INCR beat i sits at the aligned base plus i transfers
  always_comb
  begin
    if (burst_q == axi_bridge_pkg::FIXED)
    begin
      next_addr = addr_q;
    end
    else
    begin
      next_addr = base_q + ((`AXI_ADDR_BITS'(beat_cnt) + 1'b1) << size_q);
    end
  end

  // ============================
  // Control
  // ============================
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state       <= axi_bridge_pkg::SPLIT_IDLE;
      tag_pending <= 1'b0;
      beat_cnt    <= '0;
    end
    else
    begin
      case (state)
        axi_bridge_pkg::SPLIT_IDLE:
          if (ar_fire)
          begin
            state <= axi_bridge_pkg::SPLIT_ISSUE;
          end
        axi_bridge_pkg::SPLIT_ISSUE:
          if (beat_fire && last_beat)
          begin
            state <= axi_bridge_pkg::SPLIT_IDLE;
          end
        default:
          state <= axi_bridge_pkg::SPLIT_IDLE;
      endcase

      if (ar_fire)
      begin
        tag_pending <= 1'b1;
      end
      else if (tag.ready)
      begin
        tag_pending <= 1'b0;
      end

      if (ar_fire)
      begin
        beat_cnt <= '0;
      end
      else if (beat_fire)
      begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // ============================
  // Burst fields
  // ============================
  always_ff @(posedge clk)
  begin
    if (ar_fire)
    begin
      id_q    <= ar_id;
      len_q   <= ar_len;
      size_q  <= ar_size;
      burst_q <= ar_burst;
      prot_q  <= ar_prot;
      addr_q  <= ar_addr;
      base_q  <= ar_addr & ({`AXI_ADDR_BITS{1'b1}} << ar_size);
    end
    else if (beat_fire)
    begin
      addr_q <= next_addr;
    end
  end

  a_burst_legal: assert property (@(posedge clk) disable iff (!rstn)
    ar_fire |-> (ar_burst == axi_bridge_pkg::FIXED || ar_burst == axi_bridge_pkg::INCR));

endmodule

// File: hw/axi4_read_bridge.sv
// ============================
// AXI4 to AXI4-Lite read bridge, top level. AXI4 slave AR/R on the
// s_ pins, AXI4-Lite master AR/R on the m_ pins.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module axi4_read_bridge (
  input  logic                      clk,
  input  logic                      rstn,
  // AXI4 slave read address
  input  logic                      s_ar_valid,
  output logic                      s_ar_ready,
  input  logic [`AXI_ID_BITS-1:0]   s_ar_id,
  input  logic [`AXI_ADDR_BITS-1:0] s_ar_addr,
  input  logic [`AXI_LEN_BITS-1:0]  s_ar_len,
  input  logic [`AXI_SIZE_BITS-1:0] s_ar_size,
  input  logic [1:0]                s_ar_burst,
  input  logic [`AXI_PROT_BITS-1:0] s_ar_prot,
  // AXI4 slave read data
  output logic                      s_r_valid,
  input  logic                      s_r_ready,
  output logic [`AXI_ID_BITS-1:0]   s_r_id,
  output logic [`AXI_DATA_BITS-1:0] s_r_data,
  output logic [`AXI_RESP_BITS-1:0] s_r_resp,
  output logic                      s_r_last,
  // AXI4-Lite master read address
  output logic                      m_ar_valid,
  input  logic                      m_ar_ready,
  output logic [`AXI_ADDR_BITS-1:0] m_ar_addr,
  output logic [`AXI_PROT_BITS-1:0] m_ar_prot,
  // AXI4-Lite master read data
  input  logic                      m_r_valid,
  output logic                      m_r_ready,
  input  logic [`AXI_DATA_BITS-1:0] m_r_data,
  input  logic [`AXI_RESP_BITS-1:0] m_r_resp
);

  lite_ar_if   req_if ();
  lite_r_if    rsp_if ();
  burst_tag_if tag_push_if ();
  burst_tag_if tag_pop_if ();

  ar_burst_splitter u_splitter (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (s_ar_valid),
    .ar_ready (s_ar_ready),
    .ar_id    (s_ar_id),
    .ar_addr  (s_ar_addr),
    .ar_len   (s_ar_len),
    .ar_size  (s_ar_size),
    .ar_burst (axi_bridge_pkg::burst_e'(s_ar_burst)),
    .ar_prot  (s_ar_prot),
    .req      (req_if.master),
    .tag      (tag_push_if.master)
  );

  // ============================
  // Buffers
  // ============================
  sync_fifo #(
    .WIDTH (`AXI_ADDR_BITS + `AXI_PROT_BITS),
    .DEPTH (`LITE_FIFO_DEPTH)
  ) u_req_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (req_if.valid),
    .in_ready  (req_if.ready),
    .in_data   ({req_if.addr, req_if.prot}),
    .out_valid (m_ar_valid),
    .out_ready (m_ar_ready),
    .out_data  ({m_ar_addr, m_ar_prot})
  );

  sync_fifo #(
    .WIDTH (`AXI_ID_BITS + `AXI_LEN_BITS),
    .DEPTH (`TAG_FIFO_DEPTH)
  ) u_tag_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (tag_push_if.valid),
    .in_ready  (tag_push_if.ready),
    .in_data   ({tag_push_if.id, tag_push_if.len}),
    .out_valid (tag_pop_if.valid),
    .out_ready (tag_pop_if.ready),
    .out_data  ({tag_pop_if.id, tag_pop_if.len})
  );

  sync_fifo #(
    .WIDTH (`AXI_DATA_BITS + `AXI_RESP_BITS),
    .DEPTH (`LITE_FIFO_DEPTH)
  ) u_rsp_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (m_r_valid),
    .in_ready  (m_r_ready),
    .in_data   ({m_r_data, m_r_resp}),
    .out_valid (rsp_if.valid),
    .out_ready (rsp_if.ready),
    .out_data  ({rsp_if.data, rsp_if.resp})
  );

  r_beat_merger u_merger (
    .clk     (clk),
    .rstn    (rstn),
    .rsp     (rsp_if.slave),
    .tag     (tag_pop_if.slave),
    .r_valid (s_r_valid),
    .r_ready (s_r_ready),
    .r_id    (s_r_id),
    .r_data  (s_r_data),
    .r_resp  (s_r_resp),
    .r_last  (s_r_last)
  );

endmodule

// File: hw/axi_bridge_config.svh
// ============================
// Bus widths and FIFO depths for the AXI4 to AXI4-Lite read bridge.
// Included by every RTL file that sizes a port or a buffer.
// ============================

`ifndef AXI_BRIDGE_CONFIG_SVH
`define AXI_BRIDGE_CONFIG_SVH

// AXI field widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_ID_BITS 4
`define AXI_LEN_BITS 8
`define AXI_SIZE_BITS 3
`define AXI_PROT_BITS 3
`define AXI_RESP_BITS 2

// Lite request and response buffering
`define LITE_FIFO_DEPTH 4
// Bursts in flight between splitter and merger
`define TAG_FIFO_DEPTH 4

`endif

// File: hw/axi_bridge_pkg.sv
// ============================
// Shared types of the read bridge: AXI burst and response codes
// and the state encodings of the splitter and merger FSMs.
// ============================

package axi_bridge_pkg;

  // AXI4 ARBURST encoding
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } burst_e;

  // AXI RRESP encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    SPLIT_IDLE,
    SPLIT_ISSUE
  } split_state_e;

  typedef enum logic [1:0] {
    MERGE_IDLE,
    MERGE_BEAT
  } merge_state_e;

endpackage

// File: hw/bridge_if.sv
// ============================
// Valid/ready links inside the read bridge. The master modport
// drives valid and payload, the slave modport drives ready.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

// Lite read request, one per beat
interface lite_ar_if;
  logic                      valid;
  logic                      ready;
  logic [`AXI_ADDR_BITS-1:0] addr;
  logic [`AXI_PROT_BITS-1:0] prot;

  modport master (
    output valid,
    output addr,
    output prot,
    input  ready
  );

  modport slave (
    input  valid,
    input  addr,
    input  prot,
    output ready
  );
endinterface

// Lite read response
interface lite_r_if;
  logic                      valid;
  logic                      ready;
  logic [`AXI_DATA_BITS-1:0] data;
  logic [`AXI_RESP_BITS-1:0] resp;

  modport master (
    output valid,
    output data,
    output resp,
    input  ready
  );

  modport slave (
    input  valid,
    input  data,
    input  resp,
    output ready
  );
endinterface

// One tag per AXI4 burst, carries what the R side needs
interface burst_tag_if;
  logic                     valid;
  logic                     ready;
  logic [`AXI_ID_BITS-1:0]  id;
  logic [`AXI_LEN_BITS-1:0] len;

  modport master (
    output valid,
    output id,
    output len,
    input  ready
  );

  modport slave (
    input  valid,
    input  id,
    input  len,
    output ready
  );
endinterface

// File: hw/r_beat_merger.sv
// ============================
// Rebuilds the AXI4 R burst. Pops one burst tag, then forwards
// len+1 Lite responses as R beats with the burst id and last.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module r_beat_merger (
  input  logic                      clk,
  input  logic                      rstn,
  lite_r_if.slave                   rsp,
  burst_tag_if.slave                tag,
  output logic                      r_valid,
  input  logic                      r_ready,
  output logic [`AXI_ID_BITS-1:0]   r_id,
  output logic [`AXI_DATA_BITS-1:0] r_data,
  output axi_bridge_pkg::resp_e     r_resp,
  output logic                      r_last
);

  axi_bridge_pkg::merge_state_e state;

  logic [`AXI_ID_BITS-1:0]  id_q;
  logic [`AXI_LEN_BITS-1:0] len_q;
  logic [`AXI_LEN_BITS-1:0] beat_cnt;
  logic                     r_fire;

  assign tag.ready = (state == axi_bridge_pkg::MERGE_IDLE);

  // Responses pass straight through, the FIFO holds them under stall
  assign r_valid   = (state == axi_bridge_pkg::MERGE_BEAT) && rsp.valid;
  assign rsp.ready = (state == axi_bridge_pkg::MERGE_BEAT) && r_ready;
  assign r_fire    = r_valid && r_ready;

  assign r_id   = id_q;
  assign r_data = rsp.data;
  assign r_resp = axi_bridge_pkg::resp_e'(rsp.resp);
  assign r_last = r_valid && (beat_cnt == len_q);

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state    <= axi_bridge_pkg::MERGE_IDLE;
      beat_cnt <= '0;
    end
    else
    begin
      case (state)
        axi_bridge_pkg::MERGE_IDLE:
          if (tag.valid)
          begin
            state    <= axi_bridge_pkg::MERGE_BEAT;
            beat_cnt <= '0;
          end
        axi_bridge_pkg::MERGE_BEAT:
          if (r_fire)
          begin
            if (r_last)
            begin
              state <= axi_bridge_pkg::MERGE_IDLE;
            end
            else
            begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        default:
          state <= axi_bridge_pkg::MERGE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (tag.valid && tag.ready)
    begin
      id_q  <= tag.id;
      len_q <= tag.len;
    end
  end

  // A stalled beat holds until the master takes it
  a_beat_hold: assert property (@(posedge clk) disable iff (!rstn)
    r_valid && !r_ready |=> r_valid && $stable({r_id, r_data, r_resp, r_last}));

endmodule

// File: hw/sync_fifo.sv
// ============================
// Synchronous valid/ready FIFO. Circular buffer with a read pointer
// and an occupancy count; output data is read combinationally.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;
  logic [PTR_BITS:0]   wr_sum;
  logic [PTR_BITS-1:0] wr_idx;
  logic                push;
  logic                pop;

  assign in_ready  = (count != (PTR_BITS+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Write slot is rd_ptr + count, wrapped at DEPTH
  assign wr_sum = {1'b0, rd_ptr} + count;
  assign wr_idx = (wr_sum >= (PTR_BITS+1)'(DEPTH)) ?
                  PTR_BITS'(wr_sum - (PTR_BITS+1)'(DEPTH)) : PTR_BITS'(wr_sum);

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_idx] <= in_data;
    end
  end

  // Upstream holds valid and data until the FIFO takes them
  a_in_hold: assert property (@(posedge clk) disable iff (!rstn)
    in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the read bridge testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f vlog.f \
    --top-module tb_axi4_read_bridge -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_axi4_read_bridge > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "^test passed$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: testbench/lite_mem_model.sv
// ============================
// AXI4-Lite read slave for the bridge testbench. One read at a time,
// data is the address XOR 32'h5a5a0000, SLVERR in 0xF000 to 0xFFFF.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module lite_mem_model #(
  parameter logic [31:0] SEED = 32'hea97
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  input  logic [`AXI_ADDR_BITS-1:0] ar_addr,
  output logic                      r_valid,
  input  logic                      r_ready,
  output logic [`AXI_DATA_BITS-1:0] r_data,
  output logic [`AXI_RESP_BITS-1:0] r_resp
);

  logic                      ar_ready_q = 1'b0;
  logic                      r_valid_q = 1'b0;
  logic [`AXI_DATA_BITS-1:0] r_data_q = '0;
  logic [`AXI_RESP_BITS-1:0] r_resp_q = '0;
  logic [`AXI_ADDR_BITS-1:0] addr_q = '0;
  logic                      busy = 1'b0;
  logic [31:0]               lfsr = SEED;
  logic                      go_ar;
  logic                      go_r;

  assign ar_ready = ar_ready_q;
  assign r_valid  = r_valid_q;
  assign r_data   = r_data_q;
  assign r_resp   = r_resp_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(posedge clk)
  begin
    // Two bits per channel, each channel stalls about one cycle in four
    lfsr = lfsr_step(lfsr);
    go_ar = lfsr[0];
    lfsr = lfsr_step(lfsr);
    go_ar = go_ar | lfsr[0];
    lfsr = lfsr_step(lfsr);
    go_r = lfsr[0];
    lfsr = lfsr_step(lfsr);
    go_r = go_r | lfsr[0];
    if (!rstn)
    begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      busy       <= 1'b0;
    end
    else
    begin
      if (ar_valid && ar_ready_q)
      begin
        busy       <= 1'b1;
        addr_q     <= ar_addr;
        ar_ready_q <= 1'b0;
      end
      else
      begin
        ar_ready_q <= !busy && go_ar;
      end
      if (r_valid_q && r_ready)
      begin
        r_valid_q <= 1'b0;
        busy      <= 1'b0;
      end
      else if (busy && !r_valid_q && go_r)
      begin
        r_valid_q <= 1'b1;
        r_data_q  <= addr_q ^ 32'h5a5a_0000;
        r_resp_q  <= (addr_q >= 32'h0000_f000 && addr_q <= 32'h0000_ffff) ?
                     axi_bridge_pkg::SLVERR : axi_bridge_pkg::OKAY;
      end
    end
  end

endmodule

// File: testbench/tb_axi4_read_bridge.sv
// ============================
// Testbench for the AXI4 to AXI4-Lite read bridge. Sends a table of
// bursts back to back and checks every R beat in order.
// ============================

`timescale 1ns/100ps

`include "axi_bridge_config.svh"

module tb_axi4_read_bridge;

  localparam int NUM_ROWS = 7;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    axi_bridge_pkg::burst_e    burst;
  } row_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_RESP_BITS-1:0] resp;
    logic                      last;
  } beat_t;

  // One Lite read as it should leave the m_ar pins
  typedef struct packed {
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_PROT_BITS-1:0] prot;
  } req_t;

  logic                      clk = 1'b0;
  logic                      rstn = 1'b0;
  logic                      s_ar_valid = 1'b0;
  logic                      s_ar_ready;
  logic [`AXI_ID_BITS-1:0]   s_ar_id = '0;
  logic [`AXI_ADDR_BITS-1:0] s_ar_addr = '0;
  logic [`AXI_LEN_BITS-1:0]  s_ar_len = '0;
  logic [`AXI_SIZE_BITS-1:0] s_ar_size = '0;
  logic [1:0]                s_ar_burst = '0;
  logic [`AXI_PROT_BITS-1:0] s_ar_prot = '0;
  logic                      s_r_valid;
  logic                      s_r_ready = 1'b0;
  logic [`AXI_ID_BITS-1:0]   s_r_id;
  logic [`AXI_DATA_BITS-1:0] s_r_data;
  logic [`AXI_RESP_BITS-1:0] s_r_resp;
  logic                      s_r_last;
  logic                      m_ar_valid;
  logic                      m_ar_ready;
  logic [`AXI_ADDR_BITS-1:0] m_ar_addr;
  logic [`AXI_PROT_BITS-1:0] m_ar_prot;
  logic                      m_r_valid;
  logic                      m_r_ready;
  logic [`AXI_DATA_BITS-1:0] m_r_data;
  logic [`AXI_RESP_BITS-1:0] m_r_resp;

  row_t        rows [NUM_ROWS];
  beat_t       exp_q [$];
  beat_t       got;
  req_t        req_q [$];
  req_t        req_got;
  int          total_beats = 0;
  int          beats_checked = 0;
  int          cycle_limit = 0;
  int          cycle_count = 0;
  int          rst_cycles = 0;
  int          row_idx = 0;
  logic        reset_checked = 1'b0;
  logic [31:0] lfsr = 32'hea97;
  logic        go_r;

  axi4_read_bridge DUT (.*);

  lite_mem_model u_mem (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (m_ar_valid),
    .ar_ready (m_ar_ready),
    .ar_addr  (m_ar_addr),
    .r_valid  (m_r_valid),
    .r_ready  (m_r_ready),
    .r_data   (m_r_data),
    .r_resp   (m_r_resp)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // FIXED repeats the start, INCR steps from the aligned base after beat 0
  function automatic logic [31:0] expected_addr(input row_t r, input int beat);
    logic [31:0] step;
    logic [31:0] base;
    step = 32'd1 << r.size;
    base = r.addr & ~(step - 32'd1);
    if (beat == 0 || r.burst == axi_bridge_pkg::FIXED)
      return r.addr;
    return base + 32'(beat) * step;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // ============================
  // Reset, stimulus and R stalls
  // ============================
  always @(posedge clk)
  begin
    if (rst_cycles < 8)
    begin
      rst_cycles <= rst_cycles + 1;
      rstn       <= 1'b0;
    end
    else
    begin
      rstn <= 1'b1;
    end
  end

  // Next row goes out on the edge where the previous one is taken
  always @(posedge clk)
  begin
    if (!rstn)
    begin
      s_ar_valid <= 1'b0;
      row_idx    <= 0;
    end
    else if (!s_ar_valid || s_ar_ready)
    begin
      if (row_idx < NUM_ROWS)
      begin
        s_ar_valid <= 1'b1;
        s_ar_id    <= rows[row_idx].id;
        s_ar_addr  <= rows[row_idx].addr;
        s_ar_len   <= rows[row_idx].len;
        s_ar_size  <= rows[row_idx].size;
        s_ar_burst <= rows[row_idx].burst;
        s_ar_prot  <= 3'(row_idx);
        row_idx    <= row_idx + 1;
      end
      else
      begin
        s_ar_valid <= 1'b0;
      end
    end
  end

  // Two LFSR bits per cycle, ready about three cycles in four
  always @(posedge clk)
  begin
    lfsr = lfsr_step(lfsr);
    go_r = lfsr[0];
    lfsr = lfsr_step(lfsr);
    go_r = go_r | lfsr[0];
    if (!rstn)
      s_r_ready <= 1'b0;
    else
      s_r_ready <= go_r;
  end

  // ============================
  // Checks and timeout
  // ============================
  always @(posedge clk)
  begin
    if (rstn && !reset_checked)
    begin
      check_value(64'(s_ar_ready), 64'd1, "s_ar_ready after reset");
      check_value(64'(s_r_valid), 64'd0, "s_r_valid after reset");
      check_value(64'(m_ar_valid), 64'd0, "m_ar_valid after reset");
      check_value(64'(m_r_ready), 64'd1, "m_r_ready after reset");
      reset_checked <= 1'b1;
    end
    if (rstn && m_ar_valid && m_ar_ready)
    begin
      if (req_q.size() == 0)
      begin
        $display("Error at %0t: a Lite read was issued after all expected reads", $time);
        $display("test failed");
        $fatal(1, "unexpected Lite read");
      end
      req_got = req_q.pop_front();
      check_value(64'(m_ar_addr), 64'(req_got.addr), "m_ar_addr");
      check_value(64'(m_ar_prot), 64'(req_got.prot), "m_ar_prot");
    end
    if (rstn && s_r_valid && s_r_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error at %0t: an R beat arrived after all expected beats", $time);
        $display("test failed");
        $fatal(1, "unexpected R beat");
      end
      got = exp_q.pop_front();
      check_value(64'(s_r_id), 64'(got.id), "s_r_id");
      check_value(64'(s_r_data), 64'(got.data), "s_r_data");
      check_value(64'(s_r_resp), 64'(got.resp), "s_r_resp");
      check_value(64'(s_r_last), 64'(got.last), "s_r_last");
      beats_checked = beats_checked + 1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    logic [31:0] addr;
    beat_t       beat;
    req_t        req;
    // Unaligned INCR, FIXED, single beat, short mixed bursts, SLVERR crossing
    rows[0] = '{id: 4'h1, addr: 32'h0000_1006, len: 8'd7, size: 3'd2,
                burst: axi_bridge_pkg::INCR};
    rows[1] = '{id: 4'h2, addr: 32'h0000_2010, len: 8'd3, size: 3'd2,
                burst: axi_bridge_pkg::FIXED};
    rows[2] = '{id: 4'h3, addr: 32'h0000_3000, len: 8'd0, size: 3'd2,
                burst: axi_bridge_pkg::INCR};
    rows[3] = '{id: 4'h4, addr: 32'h0000_4000, len: 8'd2, size: 3'd2,
                burst: axi_bridge_pkg::INCR};
    rows[4] = '{id: 4'h5, addr: 32'h0000_5004, len: 8'd4, size: 3'd1,
                burst: axi_bridge_pkg::INCR};
    rows[5] = '{id: 4'h6, addr: 32'h0000_eff8, len: 8'd5, size: 3'd2,
                burst: axi_bridge_pkg::INCR};
    rows[6] = '{id: 4'h7, addr: 32'h0000_0100, len: 8'd1, size: 3'd2,
                burst: axi_bridge_pkg::FIXED};
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      for (int b = 0; b <= int'(rows[r].len); b++)
      begin
        addr      = expected_addr(rows[r], b);
        req.addr  = addr;
        req.prot  = 3'(r);
        req_q.push_back(req);
        beat.id   = rows[r].id;
        beat.data = addr ^ 32'h5a5a_0000;
        beat.resp = (addr >= 32'h0000_f000 && addr <= 32'h0000_ffff) ?
                    axi_bridge_pkg::SLVERR : axi_bridge_pkg::OKAY;
        beat.last = (b == int'(rows[r].len));
        exp_q.push_back(beat);
        total_beats = total_beats + 1;
      end
    end
    cycle_limit = 40 * total_beats + 100;
    wait (beats_checked == total_beats);
    repeat (10) @(posedge clk);
    if (!s_r_valid && !m_ar_valid)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("Error at %0t: the bridge is still active after the last beat", $time);
      $display("test failed");
      $fatal(1, "extra bridge activity");
    end
  end

endmodule

// File: vlog.f
+incdir+hw
hw/axi_bridge_pkg.sv
hw/bridge_if.sv
hw/sync_fifo.sv
hw/ar_burst_splitter.sv
hw/r_beat_merger.sv
hw/axi4_read_bridge.sv
testbench/lite_mem_model.sv
testbench/tb_axi4_read_bridge.sv
